/* hw/valu_pkg.sv */
`default_nettype none

package valu_pkg;

  ////////////////////
  // Widths
  ////////////////////

  // Datapath word and its byte enables
  localparam int unsigned ElenWidth = 64;
  localparam int unsigned StrbWidth = ElenWidth / 8;

  // Instruction fields
  localparam int unsigned OpWidth   = 3;
  localparam int unsigned SewWidth  = 2;
  localparam int unsigned VlWidth   = 8;
  localparam int unsigned IdWidth   = 3;
  localparam int unsigned NrVInsn   = 8;
  localparam int unsigned VRegWidth = 5;

  // Word address into the register file
  localparam int unsigned AddrWidth = 8;

  ////////////////////
  // Operation codes
  ////////////////////

  localparam logic [OpWidth-1:0] OpAdd  = 3'd0;
  localparam logic [OpWidth-1:0] OpSub  = 3'd1;
  localparam logic [OpWidth-1:0] OpAnd  = 3'd2;
  localparam logic [OpWidth-1:0] OpOr   = 3'd3;
  localparam logic [OpWidth-1:0] OpXor  = 3'd4;
  localparam logic [OpWidth-1:0] OpMinu = 3'd5;
  localparam logic [OpWidth-1:0] OpMaxu = 3'd6;
  localparam logic [OpWidth-1:0] OpSll  = 3'd7;

  // Element width codes, elements per word is 8 >> code
  localparam logic [SewWidth-1:0] Ew8  = 2'd0;
  localparam logic [SewWidth-1:0] Ew16 = 2'd1;
  localparam logic [SewWidth-1:0] Ew32 = 2'd2;
  localparam logic [SewWidth-1:0] Ew64 = 2'd3;

  // One datapath word seen at each element width
  typedef union packed {
    logic [ElenWidth/8-1:0][7:0]   w8;
    logic [ElenWidth/16-1:0][15:0] w16;
    logic [ElenWidth/32-1:0][31:0] w32;
    logic [ElenWidth-1:0]          w64;
  } elem_word_u;

endpackage

`default_nettype wire

/* hw/valu_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module valu_sequencer #(
  parameter int unsigned VInsnQueueDepth = 4,
  parameter int unsigned VregWords       = 8
) (
  input  logic                               clk_i,
  input  logic                               rst_ni,
  // Instruction input
  input  logic                               op_valid_i,
  input  logic [valu_pkg::OpWidth-1:0]       op_i,
  input  logic [valu_pkg::SewWidth-1:0]      sew_i,
  input  logic [valu_pkg::VlWidth-1:0]       vl_i,
  input  logic [valu_pkg::VRegWidth-1:0]     vd_i,
  input  logic [valu_pkg::IdWidth-1:0]       id_i,
  input  logic                               use_scalar_i,
  input  logic [valu_pkg::ElenWidth-1:0]     scalar_i,
  output logic                               op_ready_o,
  // Operand streams
  input  logic                               operand_a_valid_i,
  input  logic                               operand_b_valid_i,
  output logic                               operand_a_ready_o,
  output logic                               operand_b_ready_o,
  // Issue to the SIMD stage
  output logic [valu_pkg::OpWidth-1:0]       issue_op_o,
  output logic [valu_pkg::SewWidth-1:0]      issue_sew_o,
  output logic                               issue_use_scalar_o,
  output logic [valu_pkg::ElenWidth-1:0]     issue_scalar_o,
  output logic                               issue_fire_o,
  // Result queue side
  output logic [valu_pkg::AddrWidth-1:0]     push_addr_o,
  output logic [valu_pkg::IdWidth-1:0]       push_id_o,
  output logic [valu_pkg::StrbWidth-1:0]     push_be_o,
  input  logic                               rq_not_full_i,
  input  logic                               rq_pop_i,
  output logic [valu_pkg::NrVInsn-1:0]       done_o
);

  localparam int unsigned PtrW  = (VInsnQueueDepth > 1) ? $clog2(VInsnQueueDepth) : 1;
  localparam int unsigned CntW  = $clog2(VInsnQueueDepth + 1);
  localparam int unsigned VlW   = valu_pkg::VlWidth;
  localparam int unsigned AddrW = valu_pkg::AddrWidth;

  ////////////////////
  // Instruction queue
  ////////////////////

  logic [valu_pkg::OpWidth-1:0]   insn_op     [VInsnQueueDepth];
  logic [valu_pkg::SewWidth-1:0]  insn_sew    [VInsnQueueDepth];
  logic [VlW-1:0]                 insn_vl     [VInsnQueueDepth];
  logic [valu_pkg::VRegWidth-1:0] insn_vd     [VInsnQueueDepth];
  logic [valu_pkg::IdWidth-1:0]   insn_id     [VInsnQueueDepth];
  logic                           insn_scalar [VInsnQueueDepth];
  logic [valu_pkg::ElenWidth-1:0] insn_sval   [VInsnQueueDepth];

  // One pointer per phase, counts of instructions still to issue and commit
  logic [PtrW-1:0] accept_pnt_q, issue_pnt_q, commit_pnt_q;
  logic [CntW-1:0] issue_cnt_q, commit_cnt_q;
  // Elements already issued and committed for the head instructions
  logic [VlW-1:0]  issue_elems_q, commit_elems_q;

  logic accept;
  logic issue_valid, issue_last;
  logic commit_valid, commit_last;

  // Wrap a queue pointer
  function automatic logic [PtrW-1:0] next_pnt(input logic [PtrW-1:0] pnt);
    if (pnt == PtrW'(VInsnQueueDepth - 1)) begin
      return '0;
    end
    return pnt + 1'b1;
  endfunction

  // Full only when every slot waits for commit
  assign op_ready_o = (commit_cnt_q != CntW'(VInsnQueueDepth));
  assign accept     = op_valid_i && op_ready_o;

  always_ff @(posedge clk_i) begin
    if (accept) begin
      insn_op[accept_pnt_q]     <= op_i;
      insn_sew[accept_pnt_q]    <= sew_i;
      insn_vl[accept_pnt_q]     <= vl_i;
      insn_vd[accept_pnt_q]     <= vd_i;
      insn_id[accept_pnt_q]     <= id_i;
      insn_scalar[accept_pnt_q] <= use_scalar_i;
      insn_sval[accept_pnt_q]   <= scalar_i;
    end
  end

  ////////////////////
  // Issue
  ////////////////////

  logic [VlW-1:0] issue_rem, issue_epw, issue_elems, issue_bytes;

  assign issue_op_o         = insn_op[issue_pnt_q];
  assign issue_sew_o        = insn_sew[issue_pnt_q];
  assign issue_use_scalar_o = insn_scalar[issue_pnt_q];
  assign issue_scalar_o     = insn_sval[issue_pnt_q];
  assign push_id_o          = insn_id[issue_pnt_q];

  assign issue_valid = (issue_cnt_q != '0);
  assign issue_rem   = insn_vl[issue_pnt_q] - issue_elems_q;
  // Elements per word, capped by what is left
  assign issue_epw   = VlW'(8) >> issue_sew_o;
  assign issue_elems = (issue_epw < issue_rem) ? issue_epw : issue_rem;
  assign issue_bytes = issue_elems << issue_sew_o;

  // Issue needs B, A unless scalar, and room in the result queue
  assign issue_fire_o = issue_valid && rq_not_full_i && operand_b_valid_i &&
                        (operand_a_valid_i || issue_use_scalar_o);
  assign issue_last   = issue_fire_o && (issue_elems == issue_rem);

  assign operand_a_ready_o = issue_fire_o && !issue_use_scalar_o;
  assign operand_b_ready_o = issue_fire_o;

  // Low bytes cover the active elements
  always_comb begin
    for (int b = 0; b < valu_pkg::StrbWidth; b++) begin
      push_be_o[b] = (b < int'(issue_bytes));
    end
  end

  // Register base plus word index within the register
  assign push_addr_o = AddrW'(insn_vd[issue_pnt_q]) * AddrW'(VregWords) +
                       AddrW'(issue_elems_q >> (2'd3 - issue_sew_o));

  ////////////////////
  // Commit
  ////////////////////

  logic [VlW-1:0] commit_rem, commit_epw;

  assign commit_valid = (commit_cnt_q != '0);
  assign commit_rem   = insn_vl[commit_pnt_q] - commit_elems_q;
  assign commit_epw   = VlW'(8) >> insn_sew[commit_pnt_q];
  // Remainder drops to zero on this pop
  assign commit_last  = rq_pop_i && commit_valid && (commit_rem <= commit_epw);

  always_comb begin
    done_o = '0;
    if (commit_last) begin
      done_o[insn_id[commit_pnt_q]] = 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      accept_pnt_q   <= '0;
      issue_pnt_q    <= '0;
      commit_pnt_q   <= '0;
      issue_cnt_q    <= '0;
      commit_cnt_q   <= '0;
      issue_elems_q  <= '0;
      commit_elems_q <= '0;
    end else begin
      if (accept) begin
        accept_pnt_q <= next_pnt(accept_pnt_q);
      end
      if (issue_fire_o) begin
        issue_elems_q <= issue_last ? '0 : issue_elems_q + issue_elems;
      end
      if (issue_last) begin
        issue_pnt_q <= next_pnt(issue_pnt_q);
      end
      if (rq_pop_i && commit_valid) begin
        commit_elems_q <= commit_last ? '0 : commit_elems_q + commit_epw;
      end
      if (commit_last) begin
        commit_pnt_q <= next_pnt(commit_pnt_q);
      end
      issue_cnt_q  <= issue_cnt_q + CntW'(accept) - CntW'(issue_last);
      commit_cnt_q <= commit_cnt_q + CntW'(accept) - CntW'(commit_last);
    end
  end

endmodule

`default_nettype wire

/* hw/valu_simd_alu.sv */
`timescale 1ns/1ps
`default_nettype none

module valu_simd_alu (
  input  logic [valu_pkg::OpWidth-1:0]   op_i,
  input  logic [valu_pkg::SewWidth-1:0]  sew_i,
  input  logic                           use_scalar_i,
  input  logic [valu_pkg::ElenWidth-1:0] scalar_i,
  input  logic [valu_pkg::ElenWidth-1:0] operand_a_i,
  input  logic [valu_pkg::ElenWidth-1:0] operand_b_i,
  output logic [valu_pkg::ElenWidth-1:0] result_o
);

  localparam int unsigned W = valu_pkg::ElenWidth;

  valu_pkg::elem_word_u scalar_rep, opa, opb, res;

  ////////////////////
  // Operand select
  ////////////////////

  // Low scalar element copied into every lane of the word
  always_comb begin
    scalar_rep = '0;
    case (sew_i)
      valu_pkg::Ew8:  scalar_rep.w8  = {8{scalar_i[7:0]}};
      valu_pkg::Ew16: scalar_rep.w16 = {4{scalar_i[15:0]}};
      valu_pkg::Ew32: scalar_rep.w32 = {2{scalar_i[31:0]}};
      default:        scalar_rep.w64 = scalar_i;
    endcase
  end

  always_comb begin
    if (use_scalar_i) begin
      opa = scalar_rep;
    end else begin
      opa = operand_a_i;
    end
  end

  assign opb = operand_b_i;

  ////////////////////
  // Element operation
  ////////////////////

  // Operands arrive zero-extended, the caller truncates
  // B is the left operand, shift amount masked to the element width
  function automatic logic [W-1:0] elem_op(input logic [valu_pkg::OpWidth-1:0] op,
                                           input logic [W-1:0] a,
                                           input logic [W-1:0] b,
                                           input logic [5:0] sh_mask);
    logic [W-1:0] r;
    case (op)
      valu_pkg::OpAdd:  r = b + a;
      valu_pkg::OpSub:  r = b - a;
      valu_pkg::OpAnd:  r = b & a;
      valu_pkg::OpOr:   r = b | a;
      valu_pkg::OpXor:  r = b ^ a;
      valu_pkg::OpMinu: r = (b < a) ? b : a;
      valu_pkg::OpMaxu: r = (b > a) ? b : a;
      default:          r = b << (a[5:0] & sh_mask);
    endcase
    return r;
  endfunction

  // Same operation on every element of the chosen width
  always_comb begin
    res = '0;
    case (sew_i)
      valu_pkg::Ew8: begin
        for (int i = 0; i < W / 8; i++) begin
          res.w8[i] = 8'(elem_op(op_i, W'(opa.w8[i]), W'(opb.w8[i]), 6'd7));
        end
      end
      valu_pkg::Ew16: begin
        for (int i = 0; i < W / 16; i++) begin
          res.w16[i] = 16'(elem_op(op_i, W'(opa.w16[i]), W'(opb.w16[i]), 6'd15));
        end
      end
      valu_pkg::Ew32: begin
        for (int i = 0; i < W / 32; i++) begin
          res.w32[i] = 32'(elem_op(op_i, W'(opa.w32[i]), W'(opb.w32[i]), 6'd31));
        end
      end
      default: res.w64 = elem_op(op_i, opa.w64, opb.w64, 6'd63);
    endcase
  end

  assign result_o = res;

endmodule

`default_nettype wire

/* hw/valu_result_queue.sv */
`timescale 1ns/1ps
`default_nettype none

module valu_result_queue #(
  parameter int unsigned ResultQueueDepth = 2
) (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  // Push side from the issue stage
  input  logic                           push_i,
  input  logic [valu_pkg::ElenWidth-1:0] push_data_i,
  input  logic [valu_pkg::AddrWidth-1:0] push_addr_i,
  input  logic [valu_pkg::IdWidth-1:0]   push_id_i,
  input  logic [valu_pkg::StrbWidth-1:0] push_be_i,
  output logic                           not_full_o,
  output logic                           pop_o,
  // Register file write port
  output logic                           wr_req_o,
  output logic [valu_pkg::AddrWidth-1:0] wr_addr_o,
  output logic [valu_pkg::IdWidth-1:0]   wr_id_o,
  output logic [valu_pkg::ElenWidth-1:0] wr_data_o,
  output logic [valu_pkg::StrbWidth-1:0] wr_be_o,
  input  logic                           wr_gnt_i
);

  localparam int unsigned PtrW = (ResultQueueDepth > 1) ? $clog2(ResultQueueDepth) : 1;
  localparam int unsigned CntW = $clog2(ResultQueueDepth + 1);

  // Entry payload
  logic [valu_pkg::ElenWidth-1:0] q_data [ResultQueueDepth];
  logic [valu_pkg::AddrWidth-1:0] q_addr [ResultQueueDepth];
  logic [valu_pkg::IdWidth-1:0]   q_id   [ResultQueueDepth];
  logic [valu_pkg::StrbWidth-1:0] q_be   [ResultQueueDepth];

  logic [PtrW-1:0] rd_pnt_q, wr_pnt_q;
  logic [CntW-1:0] cnt_q;
  logic            push_en;

  function automatic logic [PtrW-1:0] next_pnt(input logic [PtrW-1:0] pnt);
    if (pnt == PtrW'(ResultQueueDepth - 1)) begin
      return '0;
    end
    return pnt + 1'b1;
  endfunction

  assign not_full_o = (cnt_q != CntW'(ResultQueueDepth));
  assign push_en    = push_i && not_full_o;

  ////////////////////
  // Write port
  ////////////////////

  // Head entry drives the port and holds until granted
  assign wr_req_o  = (cnt_q != '0);
  assign wr_addr_o = q_addr[rd_pnt_q];
  assign wr_id_o   = q_id[rd_pnt_q];
  assign wr_data_o = q_data[rd_pnt_q];
  assign wr_be_o   = q_be[rd_pnt_q];
  assign pop_o     = wr_req_o && wr_gnt_i;

  always_ff @(posedge clk_i) begin
    if (push_en) begin
      q_data[wr_pnt_q] <= push_data_i;
      q_addr[wr_pnt_q] <= push_addr_i;
      q_id[wr_pnt_q]   <= push_id_i;
      q_be[wr_pnt_q]   <= push_be_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_pnt_q <= '0;
      wr_pnt_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (push_en) begin
        wr_pnt_q <= next_pnt(wr_pnt_q);
      end
      if (pop_o) begin
        rd_pnt_q <= next_pnt(rd_pnt_q);
      end
      // Push and pop together keep the count
      cnt_q <= cnt_q + CntW'(push_en) - CntW'(pop_o);
    end
  end

endmodule

`default_nettype wire

/* hw/valu_lane.sv */
`timescale 1ns/1ps
`default_nettype none

module valu_lane #(
  parameter int unsigned VInsnQueueDepth  = 4,
  parameter int unsigned ResultQueueDepth = 2,
  parameter int unsigned VregWords        = 8
) (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  // Instruction input
  input  logic                           op_valid_i,
  output logic                           op_ready_o,
  input  logic [valu_pkg::OpWidth-1:0]   op_i,
  input  logic [valu_pkg::SewWidth-1:0]  sew_i,
  input  logic [valu_pkg::VlWidth-1:0]   vl_i,
  input  logic [valu_pkg::VRegWidth-1:0] vd_i,
  input  logic [valu_pkg::IdWidth-1:0]   id_i,
  input  logic                           use_scalar_i,
  input  logic [valu_pkg::ElenWidth-1:0] scalar_i,
  // Operand streams
  input  logic [valu_pkg::ElenWidth-1:0] operand_a_i,
  input  logic                           operand_a_valid_i,
  output logic                           operand_a_ready_o,
  input  logic [valu_pkg::ElenWidth-1:0] operand_b_i,
  input  logic                           operand_b_valid_i,
  output logic                           operand_b_ready_o,
  // Register file write port
  output logic                           wr_req_o,
  output logic [valu_pkg::AddrWidth-1:0] wr_addr_o,
  output logic [valu_pkg::IdWidth-1:0]   wr_id_o,
  output logic [valu_pkg::ElenWidth-1:0] wr_data_o,
  output logic [valu_pkg::StrbWidth-1:0] wr_be_o,
  input  logic                           wr_gnt_i,
  // Instruction completion
  output logic [valu_pkg::NrVInsn-1:0]   done_o
);

  // Issue controls toward the datapath
  logic [valu_pkg::OpWidth-1:0]   issue_op;
  logic [valu_pkg::SewWidth-1:0]  issue_sew;
  logic                           issue_use_scalar;
  logic [valu_pkg::ElenWidth-1:0] issue_scalar;
  logic                           issue_fire;

  // Word tags and result queue status
  logic [valu_pkg::AddrWidth-1:0] push_addr;
  logic [valu_pkg::IdWidth-1:0]   push_id;
  logic [valu_pkg::StrbWidth-1:0] push_be;
  logic                           rq_not_full;
  logic                           rq_pop;
  logic [valu_pkg::ElenWidth-1:0] alu_result;

  ////////////////////
  // Stage 1
  ////////////////////

  valu_sequencer #(
    .VInsnQueueDepth (VInsnQueueDepth),
    .VregWords       (VregWords)
  ) i_sequencer (
    .clk_i              (clk_i),
    .rst_ni             (rst_ni),
    .op_valid_i         (op_valid_i),
    .op_i               (op_i),
    .sew_i              (sew_i),
    .vl_i               (vl_i),
    .vd_i               (vd_i),
    .id_i               (id_i),
    .use_scalar_i       (use_scalar_i),
    .scalar_i           (scalar_i),
    .op_ready_o         (op_ready_o),
    .operand_a_valid_i  (operand_a_valid_i),
    .operand_b_valid_i  (operand_b_valid_i),
    .operand_a_ready_o  (operand_a_ready_o),
    .operand_b_ready_o  (operand_b_ready_o),
    .issue_op_o         (issue_op),
    .issue_sew_o        (issue_sew),
    .issue_use_scalar_o (issue_use_scalar),
    .issue_scalar_o     (issue_scalar),
    .issue_fire_o       (issue_fire),
    .push_addr_o        (push_addr),
    .push_id_o          (push_id),
    .push_be_o          (push_be),
    .rq_not_full_i      (rq_not_full),
    .rq_pop_i           (rq_pop),
    .done_o             (done_o)
  );

  ////////////////////
  // Stage 2
  ////////////////////

  valu_simd_alu i_simd_alu (
    .op_i         (issue_op),
    .sew_i        (issue_sew),
    .use_scalar_i (issue_use_scalar),
    .scalar_i     (issue_scalar),
    .operand_a_i  (operand_a_i),
    .operand_b_i  (operand_b_i),
    .result_o     (alu_result)
  );

  ////////////////////
  // Stage 3
  ////////////////////

  // Fire doubles as the push strobe
  valu_result_queue #(
    .ResultQueueDepth (ResultQueueDepth)
  ) i_result_queue (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .push_i      (issue_fire),
    .push_data_i (alu_result),
    .push_addr_i (push_addr),
    .push_id_i   (push_id),
    .push_be_i   (push_be),
    .not_full_o  (rq_not_full),
    .pop_o       (rq_pop),
    .wr_req_o    (wr_req_o),
    .wr_addr_o   (wr_addr_o),
    .wr_id_o     (wr_id_o),
    .wr_data_o   (wr_data_o),
    .wr_be_o     (wr_be_o),
    .wr_gnt_i    (wr_gnt_i)
  );

endmodule

`default_nettype wire

/* tests/valu_tb_assertions.sv */
`timescale 1ns/1ps
`default_nettype none

module valu_tb_assertions #(
  parameter int unsigned VInsnQueueDepth = 4,
  parameter int unsigned VregWords       = 8
) (
  input logic                           clk_i,
  input logic                           rst_ni,
  input logic                           op_valid_i,
  input logic                           op_ready_o,
  input logic [valu_pkg::SewWidth-1:0]  sew_i,
  input logic [valu_pkg::VlWidth-1:0]   vl_i,
  input logic [valu_pkg::VRegWidth-1:0] vd_i,
  input logic [valu_pkg::IdWidth-1:0]   id_i,
  input logic                           wr_req_o,
  input logic [valu_pkg::AddrWidth-1:0] wr_addr_o,
  input logic [valu_pkg::IdWidth-1:0]   wr_id_o,
  input logic [valu_pkg::ElenWidth-1:0] wr_data_o,
  input logic [valu_pkg::StrbWidth-1:0] wr_be_o,
  input logic                           wr_gnt_i
);

  // Read by the testbench for its closing line
  int fail_cnt = 0;

  // Accepted instructions with the oldest at rd_pnt
  logic [valu_pkg::VRegWidth-1:0] vd_q [8];
  logic [valu_pkg::IdWidth-1:0]   id_q [8];
  logic [7:0]                     nw_q [8];
  logic [2:0] wr_pnt, rd_pnt;
  logic [3:0] open_cnt;
  logic [7:0] word_idx;
  logic [valu_pkg::AddrWidth-1:0] exp_addr;
  logic accept, granted, last_word, retire;

  // Words taken by one instruction, 8 >> sew elements per word
  function automatic logic [7:0] word_count(input logic [valu_pkg::VlWidth-1:0] vl,
                                            input logic [valu_pkg::SewWidth-1:0] sew);
    int epw;
    epw = 8 >> sew;
    return 8'((int'(vl) + epw - 1) / epw);
  endfunction

  assign accept    = op_valid_i && op_ready_o;
  assign granted   = wr_req_o && wr_gnt_i;
  assign last_word = (word_idx + 8'd1 == nw_q[rd_pnt]);
  assign retire    = granted && last_word;
  // Register base plus index of the word inside the register
  assign exp_addr = valu_pkg::AddrWidth'(vd_q[rd_pnt]) * valu_pkg::AddrWidth'(VregWords) +
                    word_idx;

  always_ff @(posedge clk_i) begin
    if (accept) begin
      vd_q[wr_pnt] <= vd_i;
      id_q[wr_pnt] <= id_i;
      nw_q[wr_pnt] <= word_count(vl_i, sew_i);
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_pnt   <= '0;
      rd_pnt   <= '0;
      open_cnt <= '0;
      word_idx <= '0;
    end else begin
      if (accept) begin
        wr_pnt <= wr_pnt + 3'd1;
      end
      if (granted) begin
        word_idx <= last_word ? 8'd0 : word_idx + 8'd1;
      end
      if (retire) begin
        rd_pnt <= rd_pnt + 3'd1;
      end
      open_cnt <= open_cnt + 4'(accept) - 4'(retire);
    end
  end

  ////////////////////
  // Properties
  ////////////////////

  // Address and id of every granted word
  addr_id_chk: assert property (@(posedge clk_i) disable iff (!rst_ni)
    granted |-> (open_cnt != 4'd0 && wr_addr_o == exp_addr && wr_id_o == id_q[rd_pnt]))
    else begin
      fail_cnt++;
      $error("CHECK FAILED write_port: addr/id expected %h/%0d actual %h/%0d",
             exp_addr, id_q[rd_pnt], $sampled(wr_addr_o), $sampled(wr_id_o));
    end

  // Waiting request holds its payload
  hold_chk: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (wr_req_o && !wr_gnt_i) |=> (wr_req_o && $stable(wr_addr_o) && $stable(wr_id_o) &&
                                 $stable(wr_data_o) && $stable(wr_be_o)))
    else begin
      fail_cnt++;
      $error("Write request dropped or changed before it was granted");
    end

  // Queue full exactly when four instructions are open
  full_chk: assert property (@(posedge clk_i) disable iff (!rst_ni)
    op_ready_o == (open_cnt != 4'(VInsnQueueDepth)))
    else begin
      fail_cnt++;
      $error("CHECK FAILED queue_full: op_ready_o expected %b actual %b",
             open_cnt != 4'(VInsnQueueDepth), $sampled(op_ready_o));
    end

endmodule

bind valu_lane valu_tb_assertions #(
  .VInsnQueueDepth (VInsnQueueDepth),
  .VregWords       (VregWords)
) u_lane_assert (
  .clk_i      (clk_i),
  .rst_ni     (rst_ni),
  .op_valid_i (op_valid_i),
  .op_ready_o (op_ready_o),
  .sew_i      (sew_i),
  .vl_i       (vl_i),
  .vd_i       (vd_i),
  .id_i       (id_i),
  .wr_req_o   (wr_req_o),
  .wr_addr_o  (wr_addr_o),
  .wr_id_o    (wr_id_o),
  .wr_data_o  (wr_data_o),
  .wr_be_o    (wr_be_o),
  .wr_gnt_i   (wr_gnt_i)
);

`default_nettype wire

/* tests/valu_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module valu_tb;

  // About 150 words at a few cycles each, with wide margin
  localparam int TimeoutCycles = 4000;

  logic        clk_i, rst_ni;
  logic        op_valid_i, op_ready_o, use_scalar_i;
  logic [2:0]  op_i, id_i;
  logic [1:0]  sew_i;
  logic [7:0]  vl_i;
  logic [4:0]  vd_i;
  logic [63:0] scalar_i, operand_a_i, operand_b_i;
  logic        operand_a_valid_i, operand_a_ready_o, operand_b_valid_i, operand_b_ready_o;
  logic        wr_req_o, wr_gnt_i;
  logic [7:0]  wr_addr_o, wr_be_o, done_o;
  logic [2:0]  wr_id_o;
  logic [63:0] wr_data_o;

  int    seed = 74;
  int    errors = 0;
  int    cycles = 0;
  string test_name = "reset";
  logic  hold_gnt = 1'b0;
  logic [2:0] next_id = 3'd0;

  // Operand words in stream order, expected writes in issue order
  logic [63:0] a_q[$];
  logic [63:0] b_q[$];
  logic        na_q[$];
  logic [63:0] exp_data_q[$];
  logic [7:0]  exp_be_q[$];
  logic [7:0]  exp_done_q[$];

  // Heads of the queues
  logic        exp_valid = 1'b0;
  logic [63:0] exp_data = '0;
  logic [7:0]  exp_be = '0;
  logic [7:0]  exp_done = '0;
  logic        need_a = 1'b0;
  logic [7:0]  done_expect;

  valu_lane dut_i (.*);

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  ////////////////////
  // Reference model
  ////////////////////

  // Per element, B is the left operand
  function automatic logic [63:0] model_word(input logic [2:0] op, input logic [1:0] sew,
                                            input logic [63:0] a, input logic [63:0] b);
    int          ew;
    int          i;
    logic [63:0] mask;
    logic [63:0] ea;
    logic [63:0] eb;
    logic [63:0] r;
    logic [63:0] word;
    ew   = 8 << sew;
    mask = (ew == 64) ? '1 : ((64'd1 << ew) - 64'd1);
    word = '0;
    for (i = 0; i < 64 / ew; i++) begin
      ea = (a >> (i * ew)) & mask;
      eb = (b >> (i * ew)) & mask;
      case (op)
        valu_pkg::OpAdd:  r = eb + ea;
        valu_pkg::OpSub:  r = eb - ea;
        valu_pkg::OpAnd:  r = eb & ea;
        valu_pkg::OpOr:   r = eb | ea;
        valu_pkg::OpXor:  r = eb ^ ea;
        valu_pkg::OpMinu: r = (eb < ea) ? eb : ea;
        valu_pkg::OpMaxu: r = (eb > ea) ? eb : ea;
        default:          r = eb << (ea % ew);
      endcase
      word = word | ((r & mask) << (i * ew));
    end
    return word;
  endfunction

  // Low scalar element in every slot
  function automatic logic [63:0] replicate(input logic [1:0] sew, input logic [63:0] s);
    valu_pkg::elem_word_u u;
    int i;
    u = '0;
    for (i = 0; i < 8; i++) begin
      case (sew)
        valu_pkg::Ew8:  u.w8[i] = s[7:0];
        valu_pkg::Ew16: if (i < 4) u.w16[i] = s[15:0];
        valu_pkg::Ew32: if (i < 2) u.w32[i] = s[31:0];
        default:        if (i == 0) u.w64 = s;
      endcase
    end
    return u;
  endfunction

  function automatic logic [7:0] byte_mask(input int nbytes);
    logic [15:0] ones;
    ones = (16'd1 << nbytes) - 16'd1;
    return ones[7:0];
  endfunction

  task automatic refresh_heads();
    exp_valid = (exp_data_q.size() != 0);
    if (exp_valid) begin
      exp_data = exp_data_q[0];
      exp_be   = exp_be_q[0];
      exp_done = exp_done_q[0];
    end
    need_a = (na_q.size() != 0) ? na_q[0] : 1'b0;
  endtask

  // Done only with the grant of a last word
  always_comb begin
    done_expect = (wr_req_o && wr_gnt_i && exp_valid) ? exp_done : 8'd0;
  end

  ////////////////////
  // Checks
  ////////////////////

  data_chk: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (wr_req_o && wr_gnt_i) |-> (exp_valid && wr_data_o == exp_data))
    else begin
      errors++;
      $display("CHECK FAILED %s: wr_data_o expected %h actual %h", test_name, exp_data,
               $sampled(wr_data_o));
    end

  be_chk: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (wr_req_o && wr_gnt_i) |-> (exp_valid && wr_be_o == exp_be))
    else begin
      errors++;
      $display("CHECK FAILED %s: wr_be_o expected %b actual %b", test_name, exp_be,
               $sampled(wr_be_o));
    end

  done_chk: assert property (@(posedge clk_i) disable iff (!rst_ni) done_o == done_expect)
    else begin
      errors++;
      $display("CHECK FAILED %s: done_o expected %b actual %b", test_name, done_expect,
               $sampled(done_o));
    end

  // Scalar words must leave operand A alone
  opa_chk: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (operand_a_ready_o || operand_b_ready_o) |->
      (operand_b_ready_o && operand_a_ready_o == need_a))
    else begin
      errors++;
      $display("CHECK FAILED %s: operand_a_ready_o expected %b actual %b", test_name,
               need_a, $sampled(operand_a_ready_o));
    end

  // Packed as {wr_req, a_ready, b_ready, op_ready, done}
  reset_chk: assert property (@(posedge clk_i) !rst_ni |->
    ({wr_req_o, operand_a_ready_o, operand_b_ready_o, op_ready_o, done_o} == 12'h100))
    else begin
      errors++;
      $display("CHECK FAILED reset: idle outputs expected 100 actual %h",
               $sampled({wr_req_o, operand_a_ready_o, operand_b_ready_o, op_ready_o, done_o}));
    end

  ////////////////////
  // Stimulus
  ////////////////////

  // Operand and grant drivers, random levels
  initial begin : drive_streams
    logic [31:0] rnd;
    forever begin
      @(posedge clk_i);
      #2;
      rnd = $random(seed);
      operand_a_valid_i = (a_q.size() != 0) && (rnd[1:0] != 2'b00);
      operand_b_valid_i = (b_q.size() != 0) && (rnd[3:2] != 2'b00);
      if (a_q.size() != 0) operand_a_i = a_q[0];
      if (b_q.size() != 0) operand_b_i = b_q[0];
      wr_gnt_i = !hold_gnt && rnd[4];
    end
  end

  // Handshakes seen before the edge, queues retired just after it
  initial begin : track_streams
    logic a_taken;
    logic b_taken;
    logic w_taken;
    logic [63:0] junk;
    forever begin
      @(negedge clk_i);
      a_taken = operand_a_ready_o;
      b_taken = operand_b_ready_o;
      w_taken = wr_req_o && wr_gnt_i;
      @(posedge clk_i);
      #1;
      if (a_taken && a_q.size() != 0) junk = a_q.pop_front();
      if (b_taken && b_q.size() != 0) begin
        junk = b_q.pop_front();
        na_q.pop_front();
      end
      if (w_taken && exp_data_q.size() != 0) begin
        junk = exp_data_q.pop_front();
        exp_be_q.pop_front();
        exp_done_q.pop_front();
      end
      refresh_heads();
    end
  end

  // Starts just after an edge, returns on the accepting edge
  task automatic send_insn(input logic [2:0] op, input logic [1:0] sew, input int vl,
                           input logic [4:0] vd, input logic use_sc);
    int          epw;
    int          rem;
    int          elems;
    int          nwords;
    int          w;
    logic [63:0] a;
    logic [63:0] b;
    logic [63:0] s;
    epw    = 8 >> sew;
    nwords = (vl + epw - 1) / epw;
    rem    = vl;
    #1;
    s = {$random(seed), $random(seed)};
    for (w = 0; w < nwords; w++) begin
      a     = {$random(seed), $random(seed)};
      b     = {$random(seed), $random(seed)};
      elems = (rem < epw) ? rem : epw;
      b_q.push_back(b);
      if (!use_sc) a_q.push_back(a);
      na_q.push_back(!use_sc);
      exp_data_q.push_back(model_word(op, sew, use_sc ? replicate(sew, s) : a, b));
      exp_be_q.push_back(byte_mask(elems << sew));
      // Last word carries the done bit
      exp_done_q.push_back((w == nwords - 1) ? (8'd1 << next_id) : 8'd0);
      rem = rem - elems;
    end
    refresh_heads();
    #1;
    op_valid_i   = 1'b1;
    op_i         = op;
    sew_i        = sew;
    vl_i         = 8'(vl);
    vd_i         = vd;
    id_i         = next_id;
    use_scalar_i = use_sc;
    scalar_i     = s;
    @(negedge clk_i);
    while (!op_ready_o) @(negedge clk_i);
    @(posedge clk_i);
    next_id = next_id + 3'd1;
  endtask

  task automatic wait_drain();
    #2;
    op_valid_i = 1'b0;
    while (exp_data_q.size() != 0) @(posedge clk_i);
    repeat (4) @(posedge clk_i);
  endtask

  initial begin : main
    int op;
    int sew;
    int k;
    int total;
    op_valid_i = 1'b0;
    op_i = '0;
    sew_i = '0;
    vl_i = 8'd1;
    vd_i = '0;
    id_i = '0;
    use_scalar_i = 1'b0;
    scalar_i = '0;
    operand_a_i = '0;
    operand_a_valid_i = 1'b0;
    operand_b_i = '0;
    operand_b_valid_i = 1'b0;
    wr_gnt_i = 1'b0;
    rst_ni = 1'b1;
    #1 rst_ni = 1'b0;
    repeat (4) @(posedge clk_i);
    #2 rst_ni = 1'b1;
    @(posedge clk_i);

    // Every operation at every width, mostly partial last words
    test_name = "ops";
    for (op = 0; op < 8; op++) begin
      for (sew = 0; sew < 4; sew++) begin
        send_insn(3'(op), 2'(sew), 2 * (8 >> sew) - 1 + op % 3, 5'((op * 4 + sew * 7) % 32),
                  1'b0);
      end
    end
    wait_drain();

    test_name = "scalar";
    for (sew = 0; sew < 4; sew++) begin
      for (op = 0; op < 8; op += 2) begin
        send_insn(3'(op + 1), 2'(sew), 3 * (8 >> sew) + 2, 5'(31 - op - sew), 1'b1);
      end
    end
    wait_drain();

    // Grant held low, fifth instruction waits for room
    test_name = "backpressure";
    hold_gnt = 1'b1;
    fork
      for (k = 0; k < 5; k++) begin
        send_insn(3'(k), valu_pkg::Ew64, 1, 5'(k + 3), 1'b0);
      end
      begin
        repeat (40) @(posedge clk_i);
        #1 hold_gnt = 1'b0;
      end
    join
    wait_drain();

    if (a_q.size() != 0 || b_q.size() != 0) begin
      errors++;
      $display("Operand words were left unconsumed at the end of the run");
    end
    total = errors + dut_i.u_lane_assert.fail_cnt;
    $display("Errors: %0d testbench checks, %0d bound assertions", errors,
             dut_i.u_lane_assert.fail_cnt);
    if (total == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

  initial begin : watchdog
    while (cycles < TimeoutCycles) begin
      @(posedge clk_i);
      cycles++;
    end
    $display("Timeout: run did not finish within %0d cycles", TimeoutCycles);
    $display("Errors: %0d testbench checks, %0d bound assertions", errors,
             dut_i.u_lane_assert.fail_cnt);
    $display("Done: errors found");
    $finish;
  end

endmodule

`default_nettype wire

/* tb.f */
hw/valu_pkg.sv
hw/valu_sequencer.sv
hw/valu_simd_alu.sv
hw/valu_result_queue.sv
hw/valu_lane.sv
tests/valu_tb_assertions.sv
tests/valu_tb.sv

/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module valu_tb -f tb.f -o valu_sim
	./obj_dir/valu_sim +verilator+error+limit+1000 | tee /dev/stderr | grep -q "^Done: no errors$$"

clean:
	rm -rf obj_dir
